/* Bender.yml */
package:
  name: mem_sys

sources:
  - include_dirs:
      - design
    files:
      - design/mem_sys_pkg.sv
      - design/mem_queue.sv
      - design/mem_cmd_decoder.sv
      - design/mem_bank.sv
      - design/host_dev.sv
      - design/mem_sys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_mem_sys.sv

/* design/host_dev.sv */
// Host device with finish, putchar and scratch registers
// Serves one command at a time from a single response register

`default_nettype none

`include "mem_sys_settings.svh"

module host_dev (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   input  wire                          cmd_valid_i,
   output logic                         cmd_ready_o,
   input  wire                          cmd_op_i,
   input  wire [`MEM_SYS_ADDR_W-1:0]    cmd_addr_i,
   input  wire [`MEM_SYS_DATA_W-1:0]    cmd_data_i,
   output logic                         resp_valid_o,
   input  wire                          resp_ready_i,
   output logic                         resp_op_o,
   output logic [`MEM_SYS_ADDR_W-1:0]   resp_addr_o,
   output logic [`MEM_SYS_DATA_W-1:0]   resp_data_o,
   output logic                         finish_o,
   output logic                         char_valid_o,
   output logic [7:0]                   char_o
);

   logic                       cmd_accept;
   logic                       is_write;
   logic [`MEM_SYS_DATA_W-1:0] scratch_q;
   logic [`MEM_SYS_DATA_W-1:0] rd_data;

   assign cmd_ready_o = ~resp_valid_o;
   assign cmd_accept  = cmd_valid_i & cmd_ready_o;
   assign is_write    = (cmd_op_i == mem_sys_pkg::MEM_OP_WRITE);

   // Unmapped reads return zero
   assign rd_data = (cmd_addr_i == `MEM_SYS_SCRATCH_ADDR) ? scratch_q : '0;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         resp_valid_o <= 1'b0;
         finish_o     <= 1'b0;
         char_valid_o <= 1'b0;
         scratch_q    <= '0;
      end
      else
      begin
         if (cmd_accept)
         begin
            resp_valid_o <= 1'b1;
         end
         else if (resp_ready_i)
         begin
            resp_valid_o <= 1'b0;
         end
         if (cmd_accept && is_write && (cmd_addr_i == `MEM_SYS_FINISH_ADDR))
         begin
            finish_o <= 1'b1;
         end
         char_valid_o <= cmd_accept & is_write & (cmd_addr_i == `MEM_SYS_PUTCHAR_ADDR);
         if (cmd_accept && is_write && (cmd_addr_i == `MEM_SYS_SCRATCH_ADDR))
         begin
            scratch_q <= cmd_data_i;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_accept)
      begin
         resp_op_o   <= cmd_op_i;
         resp_addr_o <= cmd_addr_i;
         resp_data_o <= is_write ? cmd_data_i : rd_data;
         char_o      <= cmd_data_i[7:0];
      end
   end

endmodule

`default_nettype wire

/* design/mem_bank.sv */
// Main memory bank
// Word storage behind a fixed-latency pipeline and a credit-checked response queue

`default_nettype none

`include "mem_sys_settings.svh"

module mem_bank (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   input  wire                          cmd_valid_i,
   output logic                         cmd_ready_o,
   input  wire                          cmd_op_i,
   input  wire [`MEM_SYS_ADDR_W-1:0]    cmd_addr_i,
   input  wire [`MEM_SYS_DATA_W-1:0]    cmd_data_i,
   output logic                         resp_valid_o,
   input  wire                          resp_ready_i,
   output mem_sys_pkg::mem_resp_t       resp_o
);

   localparam int lat_lp      = `MEM_SYS_LATENCY;
   localparam int depth_lp    = `MEM_SYS_QUEUE_DEPTH;
   localparam int idx_w_lp    = $clog2(`MEM_SYS_MEM_WORDS);
   localparam int off_w_lp    = $clog2(`MEM_SYS_DATA_W / 8);
   localparam int credit_w_lp = $clog2(lat_lp + depth_lp + 1);

   logic [`MEM_SYS_DATA_W-1:0]    words_q [`MEM_SYS_MEM_WORDS];
   logic [idx_w_lp-1:0]           word_idx;
   logic                          cmd_accept;
   logic [lat_lp-1:0]             pipe_valid_q;
   mem_sys_pkg::mem_resp_t        pipe_data_q [lat_lp];
   logic [$clog2(depth_lp+1)-1:0] resp_count;
   logic [credit_w_lp-1:0]        credit_used;

   // Upper address bits are ignored, so the array aliases
   assign word_idx   = cmd_addr_i[off_w_lp +: idx_w_lp];
   assign cmd_accept = cmd_valid_i & cmd_ready_o;

   // Every command in flight owns a slot in the response queue
   always_comb
   begin
      credit_used = credit_w_lp'(resp_count);
      for (int i = 0; i < lat_lp; i++)
      begin
         credit_used = credit_used + credit_w_lp'(pipe_valid_q[i]);
      end
   end

   assign cmd_ready_o = (credit_used < depth_lp);

   always_ff @(posedge clk_i)
   begin
      if (cmd_accept && (cmd_op_i == mem_sys_pkg::MEM_OP_WRITE))
      begin
         words_q[word_idx] <= cmd_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         pipe_valid_q <= '0;
      end
      else
      begin
         pipe_valid_q[0] <= cmd_accept;
         for (int i = 1; i < lat_lp; i++)
         begin
            pipe_valid_q[i] <= pipe_valid_q[i-1];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      pipe_data_q[0].op   <= mem_sys_pkg::mem_op_e'(cmd_op_i);
      pipe_data_q[0].addr <= cmd_addr_i;
      // Writes echo their data, reads sample the array
      pipe_data_q[0].data <= (cmd_op_i == mem_sys_pkg::MEM_OP_WRITE) ? cmd_data_i
                                                                      : words_q[word_idx];
      for (int i = 1; i < lat_lp; i++)
      begin
         pipe_data_q[i] <= pipe_data_q[i-1];
      end
   end

   mem_queue #(
      .payload_t (mem_sys_pkg::mem_resp_t),
      .depth_p   (depth_lp)
   ) u_resp_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (pipe_valid_q[lat_lp-1]),
      .in_ready_o  (),
      .in_data_i   (pipe_data_q[lat_lp-1]),
      .out_valid_o (resp_valid_o),
      .out_ready_i (resp_ready_i),
      .out_data_o  (resp_o),
      .count_o     (resp_count)
   );

endmodule

`default_nettype wire

/* design/mem_cmd_decoder.sv */
// Command router and response merger
// Steers commands to the bank or host by address, merges responses host first

`default_nettype none

`include "mem_sys_settings.svh"

module mem_cmd_decoder (
   input  wire                            clk_i,
   input  wire                            rst_n_i,
   input  wire                            cmd_valid_i,
   output logic                           cmd_ready_o,
   input  wire mem_sys_pkg::mem_cmd_t     cmd_i,
   output logic                           mem_valid_o,
   input  wire                            mem_ready_i,
   output logic                           mem_op_o,
   output logic [`MEM_SYS_ADDR_W-1:0]     mem_addr_o,
   output logic [`MEM_SYS_DATA_W-1:0]     mem_data_o,
   output logic                           host_valid_o,
   input  wire                            host_ready_i,
   output logic                           host_op_o,
   output logic [`MEM_SYS_ADDR_W-1:0]     host_addr_o,
   output logic [`MEM_SYS_DATA_W-1:0]     host_data_o,
   input  wire                            mem_resp_valid_i,
   output logic                           mem_resp_ready_o,
   input  wire mem_sys_pkg::mem_resp_t    mem_resp_i,
   input  wire                            host_resp_valid_i,
   output logic                           host_resp_ready_o,
   input  wire                            host_resp_op_i,
   input  wire [`MEM_SYS_ADDR_W-1:0]      host_resp_addr_i,
   input  wire [`MEM_SYS_DATA_W-1:0]      host_resp_data_i,
   output logic                           resp_valid_o,
   input  wire                            resp_ready_i,
   output logic                           resp_op_o,
   output logic [`MEM_SYS_ADDR_W-1:0]     resp_addr_o,
   output logic [`MEM_SYS_DATA_W-1:0]     resp_data_o
);

   mem_sys_pkg::mem_region_e cmd_region;
   mem_sys_pkg::mem_region_e resp_sel;
   mem_sys_pkg::mem_region_e grant_q;
   logic                     hold_q;

   assign cmd_region = (cmd_i.addr >= `MEM_SYS_IO_BASE) ? mem_sys_pkg::REGION_HOST
                                                        : mem_sys_pkg::REGION_MEM;

   assign mem_valid_o  = cmd_valid_i & (cmd_region == mem_sys_pkg::REGION_MEM);
   assign host_valid_o = cmd_valid_i & (cmd_region == mem_sys_pkg::REGION_HOST);
   assign cmd_ready_o  = (cmd_region == mem_sys_pkg::REGION_HOST) ? host_ready_i : mem_ready_i;

   assign mem_op_o    = cmd_i.op;
   assign mem_addr_o  = cmd_i.addr;
   assign mem_data_o  = cmd_i.data;
   assign host_op_o   = cmd_i.op;
   assign host_addr_o = cmd_i.addr;
   assign host_data_o = cmd_i.data;

   // A stalled response keeps its source until taken
   assign resp_sel = hold_q ? grant_q
                   : (host_resp_valid_i ? mem_sys_pkg::REGION_HOST : mem_sys_pkg::REGION_MEM);

   always_comb
   begin
      if (resp_sel == mem_sys_pkg::REGION_HOST)
      begin
         resp_valid_o = host_resp_valid_i;
         resp_op_o    = host_resp_op_i;
         resp_addr_o  = host_resp_addr_i;
         resp_data_o  = host_resp_data_i;
      end
      else
      begin
         resp_valid_o = mem_resp_valid_i;
         resp_op_o    = mem_resp_i.op;
         resp_addr_o  = mem_resp_i.addr;
         resp_data_o  = mem_resp_i.data;
      end
   end

   assign host_resp_ready_o = resp_ready_i & (resp_sel == mem_sys_pkg::REGION_HOST);
   assign mem_resp_ready_o  = resp_ready_i & (resp_sel == mem_sys_pkg::REGION_MEM);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         hold_q  <= 1'b0;
         grant_q <= mem_sys_pkg::REGION_MEM;
      end
      else
      begin
         hold_q  <= resp_valid_o & ~resp_ready_i;
         grant_q <= resp_sel;
      end
   end

endmodule

`default_nettype wire

/* design/mem_queue.sv */
// Valid/ready FIFO with a type-parameterized payload
// Circular buffer, exposes its occupancy for credit checks

`default_nettype none

module mem_queue #(
   parameter type payload_t = logic,
   parameter int  depth_p   = 4
) (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   input  wire                        in_valid_i,
   output logic                       in_ready_o,
   input  wire payload_t              in_data_i,
   output logic                       out_valid_o,
   input  wire                        out_ready_i,
   output payload_t                   out_data_o,
   output logic [$clog2(depth_p+1)-1:0] count_o
);

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;

   payload_t                     entries_q [depth_p];
   logic [ptr_w_lp-1:0]          wr_ptr_q;
   logic [ptr_w_lp-1:0]          rd_ptr_q;
   logic [$clog2(depth_p+1)-1:0] count_q;
   logic                         push;
   logic                         pop;

   assign in_ready_o  = (count_q < depth_p);
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = entries_q[rd_ptr_q];
   assign count_o     = count_q;

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            // Pointers wrap at depth, which need not be a power of two
            wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + push - pop;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         entries_q[wr_ptr_q] <= in_data_i;
      end
   end

endmodule

`default_nettype wire

/* design/mem_sys_pkg.sv */
// Memory subsystem types
// Opcode, command and response payloads, address regions

`default_nettype none

`include "mem_sys_settings.svh"

package mem_sys_pkg;

   typedef enum logic
   {
      MEM_OP_READ  = 1'b0,
      MEM_OP_WRITE = 1'b1
   } mem_op_e;

   // Command as seen at the processor-side channel
   typedef struct packed
   {
      mem_op_e                    op;
      logic [`MEM_SYS_ADDR_W-1:0] addr;
      logic [`MEM_SYS_DATA_W-1:0] data;
   } mem_cmd_t;

   // Response echoes op and address
   typedef struct packed
   {
      mem_op_e                    op;
      logic [`MEM_SYS_ADDR_W-1:0] addr;
      logic [`MEM_SYS_DATA_W-1:0] data;
   } mem_resp_t;

   // Target of a command, picked by address
   typedef enum logic
   {
      REGION_MEM  = 1'b0,
      REGION_HOST = 1'b1
   } mem_region_e;

endpackage

`default_nettype wire

/* design/mem_sys_settings.svh */
// Memory subsystem settings
// Widths, queue depth, bank latency and host register map

`ifndef MEM_SYS_SETTINGS_SVH
`define MEM_SYS_SETTINGS_SVH

// Byte address and data word widths
`define MEM_SYS_ADDR_W 16
`define MEM_SYS_DATA_W 32

// Main memory depth in words
`define MEM_SYS_MEM_WORDS 256

// Bank cycles from command acceptance to response
`define MEM_SYS_LATENCY 3

// Entries per queue
`define MEM_SYS_QUEUE_DEPTH 4

// Host region, everything at or above the base
`define MEM_SYS_IO_BASE 16'hF000
`define MEM_SYS_FINISH_ADDR 16'hF000
`define MEM_SYS_PUTCHAR_ADDR 16'hF004
`define MEM_SYS_SCRATCH_ADDR 16'hF008

`endif

/* design/mem_sys_top.sv */
// Memory subsystem top
// Command queue, address decoder, memory bank and host device

`default_nettype none

`include "mem_sys_settings.svh"

module mem_sys_top (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   input  wire                          cmd_valid_i,
   output logic                         cmd_ready_o,
   input  wire                          cmd_op_i,
   input  wire [`MEM_SYS_ADDR_W-1:0]    cmd_addr_i,
   input  wire [`MEM_SYS_DATA_W-1:0]    cmd_data_i,
   output logic                         resp_valid_o,
   input  wire                          resp_ready_i,
   output logic                         resp_op_o,
   output logic [`MEM_SYS_ADDR_W-1:0]   resp_addr_o,
   output logic [`MEM_SYS_DATA_W-1:0]   resp_data_o,
   output logic                         finish_o,
   output logic                         char_valid_o,
   output logic [7:0]                   char_o
);

   mem_sys_pkg::mem_cmd_t      cmd_in;
   mem_sys_pkg::mem_cmd_t      cmd_q;
   logic                       cmd_q_valid;
   logic                       cmd_q_ready;

   logic                       mem_valid;
   logic                       mem_ready;
   logic                       mem_op;
   logic [`MEM_SYS_ADDR_W-1:0] mem_addr;
   logic [`MEM_SYS_DATA_W-1:0] mem_data;
   logic                       mem_resp_valid;
   logic                       mem_resp_ready;
   mem_sys_pkg::mem_resp_t     mem_resp;

   logic                       host_valid;
   logic                       host_ready;
   logic                       host_op;
   logic [`MEM_SYS_ADDR_W-1:0] host_addr;
   logic [`MEM_SYS_DATA_W-1:0] host_data;
   logic                       host_resp_valid;
   logic                       host_resp_ready;
   logic                       host_resp_op;
   logic [`MEM_SYS_ADDR_W-1:0] host_resp_addr;
   logic [`MEM_SYS_DATA_W-1:0] host_resp_data;

   assign cmd_in.op   = mem_sys_pkg::mem_op_e'(cmd_op_i);
   assign cmd_in.addr = cmd_addr_i;
   assign cmd_in.data = cmd_data_i;

   mem_queue #(
      .payload_t (mem_sys_pkg::mem_cmd_t),
      .depth_p   (`MEM_SYS_QUEUE_DEPTH)
   ) u_cmd_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (cmd_valid_i),
      .in_ready_o  (cmd_ready_o),
      .in_data_i   (cmd_in),
      .out_valid_o (cmd_q_valid),
      .out_ready_i (cmd_q_ready),
      .out_data_o  (cmd_q),
      .count_o     ()
   );

   mem_cmd_decoder u_decoder (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .cmd_valid_i       (cmd_q_valid),
      .cmd_ready_o       (cmd_q_ready),
      .cmd_i             (cmd_q),
      .mem_valid_o       (mem_valid),
      .mem_ready_i       (mem_ready),
      .mem_op_o          (mem_op),
      .mem_addr_o        (mem_addr),
      .mem_data_o        (mem_data),
      .host_valid_o      (host_valid),
      .host_ready_i      (host_ready),
      .host_op_o         (host_op),
      .host_addr_o       (host_addr),
      .host_data_o       (host_data),
      .mem_resp_valid_i  (mem_resp_valid),
      .mem_resp_ready_o  (mem_resp_ready),
      .mem_resp_i        (mem_resp),
      .host_resp_valid_i (host_resp_valid),
      .host_resp_ready_o (host_resp_ready),
      .host_resp_op_i    (host_resp_op),
      .host_resp_addr_i  (host_resp_addr),
      .host_resp_data_i  (host_resp_data),
      .resp_valid_o      (resp_valid_o),
      .resp_ready_i      (resp_ready_i),
      .resp_op_o         (resp_op_o),
      .resp_addr_o       (resp_addr_o),
      .resp_data_o       (resp_data_o)
   );

   mem_bank u_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (mem_valid),
      .cmd_ready_o  (mem_ready),
      .cmd_op_i     (mem_op),
      .cmd_addr_i   (mem_addr),
      .cmd_data_i   (mem_data),
      .resp_valid_o (mem_resp_valid),
      .resp_ready_i (mem_resp_ready),
      .resp_o       (mem_resp)
   );

   host_dev u_host (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (host_valid),
      .cmd_ready_o  (host_ready),
      .cmd_op_i     (host_op),
      .cmd_addr_i   (host_addr),
      .cmd_data_i   (host_data),
      .resp_valid_o (host_resp_valid),
      .resp_ready_i (host_resp_ready),
      .resp_op_o    (host_resp_op),
      .resp_addr_o  (host_resp_addr),
      .resp_data_o  (host_resp_data),
      .finish_o     (finish_o),
      .char_valid_o (char_valid_o),
      .char_o       (char_o)
   );

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/mem_sys_pkg.sv
design/mem_queue.sv
design/mem_cmd_decoder.sv
design/mem_bank.sv
design/host_dev.sv
design/mem_sys_top.sv
test/tb_mem_sys.sv

/* test/tb_mem_sys.sv */
// Memory subsystem testbench
// Directed tests against a reference model of memory and host registers

`default_nettype none

`include "mem_sys_settings.svh"

module tb_mem_sys;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int period_lp     = 8;
   localparam int total_cmds_lp = 125;

   logic                       clk_i;
   logic                       rst_n_i;
   logic                       cmd_valid_i;
   logic                       cmd_ready_o;
   logic                       cmd_op_i;
   logic [`MEM_SYS_ADDR_W-1:0] cmd_addr_i;
   logic [`MEM_SYS_DATA_W-1:0] cmd_data_i;
   logic                       resp_valid_o;
   logic                       resp_ready_i;
   logic                       resp_op_o;
   logic [`MEM_SYS_ADDR_W-1:0] resp_addr_o;
   logic [`MEM_SYS_DATA_W-1:0] resp_data_o;
   logic                       finish_o;
   logic                       char_valid_o;
   logic [7:0]                 char_o;

   // Reference model
   logic [`MEM_SYS_DATA_W-1:0] model_mem [`MEM_SYS_MEM_WORDS];
   logic [`MEM_SYS_DATA_W-1:0] scratch_model;
   mem_sys_pkg::mem_resp_t     exp_mem_q [$];
   mem_sys_pkg::mem_resp_t     exp_host_q [$];
   logic [7:0]                 exp_chars [$];
   logic [31:0]                lcg_state = 32'ha570;
   int                         errors;
   int                         checks;
   int                         char_pulses;
   int                         putchar_writes;

   mem_sys_top u_dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_op_i     (cmd_op_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_data_i   (cmd_data_i),
      .resp_valid_o (resp_valid_o),
      .resp_ready_i (resp_ready_i),
      .resp_op_o    (resp_op_o),
      .resp_addr_o  (resp_addr_o),
      .resp_data_o  (resp_data_o),
      .finish_o     (finish_o),
      .char_valid_o (char_valid_o),
      .char_o       (char_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(period_lp / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #(total_cmds_lp * 20 * period_lp);
      $display("Timeout: the tests did not finish in the allowed time");
      $display("Regression failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Word-aligned address below the host region
   function automatic logic [`MEM_SYS_ADDR_W-1:0] rand_mem_addr();
      logic [31:0]                r;
      logic [`MEM_SYS_ADDR_W-1:0] a;
      r = next_rand();
      a = r[23:8] % `MEM_SYS_IO_BASE;
      return a & 16'hFFFC;
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   // Drives one command and records its expected response once accepted
   task automatic send_cmd(input logic op, input logic [`MEM_SYS_ADDR_W-1:0] addr,
                           input logic [`MEM_SYS_DATA_W-1:0] data);
      mem_sys_pkg::mem_resp_t exp;
      int                     idx;
      @(negedge clk_i);
      cmd_valid_i = 1'b1;
      cmd_op_i    = op;
      cmd_addr_i  = addr;
      cmd_data_i  = data;
      @(posedge clk_i);
      while (!cmd_ready_o)
      begin
         @(posedge clk_i);
      end
      exp.op   = mem_sys_pkg::mem_op_e'(op);
      exp.addr = addr;
      if (addr >= `MEM_SYS_IO_BASE)
      begin
         if (op == mem_sys_pkg::MEM_OP_WRITE)
         begin
            exp.data = data;
            if (addr == `MEM_SYS_SCRATCH_ADDR)
            begin
               scratch_model = data;
            end
            if (addr == `MEM_SYS_PUTCHAR_ADDR)
            begin
               exp_chars.push_back(data[7:0]);
               putchar_writes++;
            end
         end
         else
         begin
            exp.data = (addr == `MEM_SYS_SCRATCH_ADDR) ? scratch_model : '0;
         end
         exp_host_q.push_back(exp);
      end
      else
      begin
         idx = (addr >> 2) % `MEM_SYS_MEM_WORDS;
         if (op == mem_sys_pkg::MEM_OP_WRITE)
         begin
            model_mem[idx] = data;
            exp.data       = data;
         end
         else
         begin
            exp.data = model_mem[idx];
         end
         exp_mem_q.push_back(exp);
      end
   endtask

   task automatic release_cmd();
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_mem_q.size() != 0 || exp_host_q.size() != 0) && n < 200)
      begin
         @(posedge clk_i);
         n++;
      end
      if (exp_mem_q.size() != 0 || exp_host_q.size() != 0)
      begin
         errors++;
         $display("Responses missing: %0d memory and %0d host still expected",
                  exp_mem_q.size(), exp_host_q.size());
      end
      // A few idle cycles to catch extra responses
      repeat (5) @(negedge clk_i);
   endtask

   // Response scoreboard matched by address region
   always @(posedge clk_i)
   begin
      mem_sys_pkg::mem_resp_t exp;
      bit                     got;
      if (rst_n_i && resp_valid_o && resp_ready_i)
      begin
         got = 1'b0;
         if (resp_addr_o >= `MEM_SYS_IO_BASE)
         begin
            if (exp_host_q.size() != 0)
            begin
               exp = exp_host_q.pop_front();
               got = 1'b1;
            end
         end
         else if (exp_mem_q.size() != 0)
         begin
            exp = exp_mem_q.pop_front();
            got = 1'b1;
         end
         if (!got)
         begin
            errors++;
            $display("Response with no matching command at address 0x%0h", resp_addr_o);
         end
         else
         begin
            check_value("resp_op_o", resp_op_o, exp.op);
            check_value("resp_addr_o", resp_addr_o, exp.addr);
            check_value("resp_data_o", resp_data_o, exp.data);
         end
      end
   end

   always @(posedge clk_i)
   begin
      if (rst_n_i && char_valid_o)
      begin
         char_pulses++;
         if (exp_chars.size() == 0)
         begin
            errors++;
            $display("Character output pulsed without a putchar write");
         end
         else
         begin
            check_value("char_o", char_o, exp_chars.pop_front());
         end
      end
   end

   task automatic write_read_word();
      send_cmd(mem_sys_pkg::MEM_OP_WRITE, 16'h0010, 32'hCAFE0001);
      send_cmd(mem_sys_pkg::MEM_OP_READ, 16'h0010, 32'h0);
      release_cmd();
      wait_drain();
   endtask

   task automatic random_stream();
      logic [`MEM_SYS_ADDR_W-1:0] addrs [40];
      for (int i = 0; i < 40; i++)
      begin
         addrs[i] = rand_mem_addr();
         send_cmd(mem_sys_pkg::MEM_OP_WRITE, addrs[i], next_rand());
      end
      for (int i = 0; i < 40; i++)
      begin
         send_cmd(mem_sys_pkg::MEM_OP_READ, addrs[i], 32'h0);
      end
      release_cmd();
      wait_drain();
   endtask

   task automatic back_pressure();
      bit stall_seen;
      int wait_cycles;
      @(negedge clk_i);
      resp_ready_i = 1'b0;
      stall_seen   = 1'b0;
      wait_cycles  = 0;
      fork
         begin
            for (int i = 0; i < 6; i++)
            begin
               send_cmd(mem_sys_pkg::MEM_OP_WRITE, 16'h0200 + 16'(i * 4), next_rand());
            end
            for (int i = 0; i < 6; i++)
            begin
               send_cmd(mem_sys_pkg::MEM_OP_READ, 16'h0200 + 16'(i * 4), 32'h0);
            end
            release_cmd();
         end
         begin
            while (!stall_seen && wait_cycles < 50)
            begin
               @(posedge clk_i);
               if (cmd_valid_i && !cmd_ready_o)
               begin
                  stall_seen = 1'b1;
               end
               wait_cycles++;
            end
            repeat (4) @(posedge clk_i);
            @(negedge clk_i);
            resp_ready_i = 1'b1;
         end
      join
      if (!stall_seen)
      begin
         errors++;
         $display("Command channel never stalled while responses were held back");
      end
      wait_drain();
   endtask

   task automatic alias_read();
      send_cmd(mem_sys_pkg::MEM_OP_WRITE, 16'h0040, 32'hA11A5001);
      send_cmd(mem_sys_pkg::MEM_OP_READ, 16'h0040 + 16'(4 * `MEM_SYS_MEM_WORDS), 32'h0);
      release_cmd();
      wait_drain();
   endtask

   task automatic host_registers();
      int pulses_before;
      pulses_before = char_pulses;
      send_cmd(mem_sys_pkg::MEM_OP_WRITE, `MEM_SYS_SCRATCH_ADDR, 32'h12345678);
      send_cmd(mem_sys_pkg::MEM_OP_READ, `MEM_SYS_SCRATCH_ADDR, 32'h0);
      send_cmd(mem_sys_pkg::MEM_OP_READ, 16'hF00C, 32'h0);
      send_cmd(mem_sys_pkg::MEM_OP_WRITE, `MEM_SYS_PUTCHAR_ADDR, 32'h00000041);
      release_cmd();
      wait_drain();
      check_value("char_valid_o pulses", char_pulses - pulses_before, 1);
   endtask

   task automatic mixed_traffic();
      logic [`MEM_SYS_ADDR_W-1:0] addr;
      check_value("finish_o", finish_o, 1'b0);
      for (int i = 0; i < 6; i++)
      begin
         addr = rand_mem_addr();
         send_cmd(mem_sys_pkg::MEM_OP_WRITE, addr, next_rand());
         send_cmd(mem_sys_pkg::MEM_OP_WRITE, `MEM_SYS_SCRATCH_ADDR, next_rand());
         send_cmd(mem_sys_pkg::MEM_OP_READ, addr, 32'h0);
         send_cmd(mem_sys_pkg::MEM_OP_READ, `MEM_SYS_SCRATCH_ADDR, 32'h0);
      end
      send_cmd(mem_sys_pkg::MEM_OP_WRITE, `MEM_SYS_FINISH_ADDR, 32'h1);
      release_cmd();
      wait_drain();
      check_value("finish_o", finish_o, 1'b1);
      repeat (10) @(negedge clk_i);
      check_value("finish_o", finish_o, 1'b1);
   endtask

   initial
   begin
      rst_n_i       = 1'b0;
      cmd_valid_i   = 1'b0;
      cmd_op_i      = 1'b0;
      cmd_addr_i    = '0;
      cmd_data_i    = '0;
      resp_ready_i  = 1'b1;
      scratch_model = '0;
      errors        = 0;
      checks        = 0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      check_value("resp_valid_o", resp_valid_o, 1'b0);
      check_value("char_valid_o", char_valid_o, 1'b0);
      check_value("finish_o", finish_o, 1'b0);
      check_value("cmd_ready_o", cmd_ready_o, 1'b1);

      write_read_word();
      random_stream();
      back_pressure();
      alias_read();
      host_registers();
      mixed_traffic();
      check_value("char_valid_o pulses", char_pulses, putchar_writes);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
